//--- design/axi_pkg.sv
package axi_pkg;

    localparam int NUM_PORTS   = 2;    // fetch port and load/store port
    localparam int PORT_IDX_W  = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
    localparam int ADDR_W      = 32;   // byte address
    localparam int DATA_W      = 64;
    localparam int STRB_W      = DATA_W / 8;
    localparam int ADDR_LSB    = $clog2(STRB_W); // byte offset bits inside a word
    localparam int MEM_WORDS   = 256;
    localparam int MEM_IDX_W   = $clog2(MEM_WORDS);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic {
        RW_READ,
        RW_WRITE
    } rw_op_e;

    // bridge FSM, read path and write path share idle
    typedef enum logic [2:0] {
        LS_IDLE,
        LS_AR_WAIT,
        LS_R_WAIT,
        LS_AW_W_WAIT,   // aw and w tracked separately in here
        LS_B_WAIT
    } ls_state_e;

    typedef struct packed {
        rw_op_e              op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
        logic [STRB_W-1:0]   wstrb;
    } rw_req_t;

    typedef struct packed {
        logic [DATA_W-1:0]   rdata;   // zero for writes
        logic                err;     // slave answered slverr
    } rw_resp_t;

    // master to slave, single beat subset
    typedef struct packed {
        logic                ar_valid;
        logic [ADDR_W-1:0]   ar_addr;
        logic                aw_valid;
        logic [ADDR_W-1:0]   aw_addr;
        logic                w_valid;
        logic [DATA_W-1:0]   w_data;
        logic [STRB_W-1:0]   w_strb;
        logic                r_ready;
        logic                b_ready;
    } axi_m2s_t;

    // slave to master
    typedef struct packed {
        logic                ar_ready;
        logic                aw_ready;
        logic                w_ready;
        logic                r_valid;
        logic [DATA_W-1:0]   r_data;
        logic [1:0]          r_resp;
        logic                b_valid;
        logic [1:0]          b_resp;
    } axi_s2m_t;

endpackage

//--- design/rw_req_latch.sv
`timescale 1ns/1ps

module rw_req_latch (
    input  logic              clock,
    input  logic              reset,
    input  logic              rw_valid_i [axi_pkg::NUM_PORTS],
    input  axi_pkg::rw_req_t  rw_req_i   [axi_pkg::NUM_PORTS],
    input  logic              done_i     [axi_pkg::NUM_PORTS],
    output logic              start_o    [axi_pkg::NUM_PORTS],
    output axi_pkg::rw_req_t  req_o      [axi_pkg::NUM_PORTS]
);
    import axi_pkg::*;

    logic    busy_q  [NUM_PORTS];   // port has a request in flight
    logic    start_q [NUM_PORTS];
    rw_req_t req_q   [NUM_PORTS];   // held copy, stable until done

    // control flags
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                busy_q[p]  <= 1'b0;
                start_q[p] <= 1'b0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                start_q[p] <= rw_valid_i[p] && !busy_q[p]; // one cycle after capture
                if (rw_valid_i[p] && !busy_q[p]) begin
                    busy_q[p] <= 1'b1;
                end else if (done_i[p]) begin
                    busy_q[p] <= 1'b0;   // bridge finished
                end
            end
        end
    end

    // payload hold, loaded only on capture
    always_ff @(posedge clock) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (rw_valid_i[p] && !busy_q[p]) req_q[p] <= rw_req_i[p];
        end
    end

    assign start_o = start_q;
    assign req_o   = req_q;

endmodule

//--- design/axi_ls.sv
`timescale 1ns/1ps

module axi_ls (
    input  logic               clock,
    input  logic               reset,
    input  logic               start_i,   // one cycle, req_i already held
    input  axi_pkg::rw_req_t   req_i,
    output logic               done_o,    // one cycle
    output axi_pkg::rw_resp_t  resp_o,    // zero outside done_o
    output axi_pkg::axi_m2s_t  axi_o,
    input  axi_pkg::axi_s2m_t  axi_i
);
    import axi_pkg::*;

    ls_state_e state_q, state_d;
    logic      aw_done_q;   // aw handshake already seen
    logic      w_done_q;    // w handshake already seen
    logic      done_q;
    rw_resp_t  resp_q;

    logic ar_hs, r_hs, aw_hs, w_hs, b_hs;

    // channel drive, all straight from state
    always_comb begin
        axi_o          = '0;
        axi_o.ar_valid = (state_q == LS_AR_WAIT);
        axi_o.ar_addr  = req_i.addr;   // latch keeps it stable
        axi_o.aw_valid = (state_q == LS_AW_W_WAIT) && !aw_done_q;
        axi_o.aw_addr  = req_i.addr;
        axi_o.w_valid  = (state_q == LS_AW_W_WAIT) && !w_done_q;
        axi_o.w_data   = req_i.wdata;
        axi_o.w_strb   = req_i.wstrb;
        axi_o.r_ready  = (state_q == LS_R_WAIT);
        axi_o.b_ready  = (state_q == LS_B_WAIT);
    end

    assign ar_hs = axi_o.ar_valid && axi_i.ar_ready;
    assign r_hs  = axi_o.r_ready  && axi_i.r_valid;
    assign aw_hs = axi_o.aw_valid && axi_i.aw_ready;
    assign w_hs  = axi_o.w_valid  && axi_i.w_ready;
    assign b_hs  = axi_o.b_ready  && axi_i.b_valid;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            LS_IDLE: begin
                if (start_i) begin
                    state_d = (req_i.op == RW_WRITE) ? LS_AW_W_WAIT : LS_AR_WAIT;
                end
            end
            LS_AR_WAIT: begin
                if (ar_hs) state_d = LS_R_WAIT;
            end
            LS_R_WAIT: begin
                if (r_hs) state_d = LS_IDLE;
            end
            LS_AW_W_WAIT: begin
                // both handshakes needed, in any order or together
                if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) state_d = LS_B_WAIT;
            end
            LS_B_WAIT: begin
                if (b_hs) state_d = LS_IDLE;
            end
            default: state_d = LS_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q   <= LS_IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_d != LS_AW_W_WAIT) begin
                aw_done_q <= 1'b0;   // cleared on leaving the write address phase
                w_done_q  <= 1'b0;
            end else begin
                if (aw_hs) aw_done_q <= 1'b1;
                if (w_hs)  w_done_q  <= 1'b1;
            end
        end
    end

    // registered completion, one cycle after r or b handshake
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            done_q <= 1'b0;
            resp_q <= '0;
        end else begin
            done_q <= 1'b0;
            resp_q <= '0;
            if (r_hs) begin
                done_q       <= 1'b1;
                resp_q.rdata <= axi_i.r_data;
                resp_q.err   <= (axi_i.r_resp == RESP_SLVERR);
            end else if (b_hs) begin
                done_q     <= 1'b1;   // rdata stays zero
                resp_q.err <= (axi_i.b_resp == RESP_SLVERR);
            end
        end
    end

    assign done_o = done_q;
    assign resp_o = resp_q;

endmodule

//--- design/axi_arbiter.sv
`timescale 1ns/1ps

module axi_arbiter (
    input  logic               clock,
    input  logic               reset,
    input  axi_pkg::axi_m2s_t  m_req_i [axi_pkg::NUM_PORTS],
    output axi_pkg::axi_s2m_t  m_rsp_o [axi_pkg::NUM_PORTS],
    output axi_pkg::axi_m2s_t  s_req_o,
    input  axi_pkg::axi_s2m_t  s_rsp_i
);
    import axi_pkg::*;

    logic [PORT_IDX_W-1:0] grant_q;    // owner while locked
    logic                  locked_q;
    logic [PORT_IDX_W-1:0] rr_ptr_q;   // first port to look at next time
    logic [PORT_IDX_W-1:0] pick_idx;
    logic                  pick_valid;
    logic                  fin;        // last handshake of the owner's transaction

    // round robin search from rr_ptr_q
    always_comb begin
        int cand;
        pick_valid = 1'b0;
        pick_idx   = rr_ptr_q;
        // scan backwards so the port nearest the pointer wins
        for (int i = NUM_PORTS - 1; i >= 0; i--) begin
            cand = int'(rr_ptr_q) + i;
            if (cand >= NUM_PORTS) cand = cand - NUM_PORTS;
            if (m_req_i[cand].ar_valid || m_req_i[cand].aw_valid) begin
                pick_valid = 1'b1;
                pick_idx   = PORT_IDX_W'(cand);
            end
        end
    end

    // owner onto the slave, nothing while ungranted
    assign s_req_o = locked_q ? m_req_i[grant_q] : '0;

    // response back to the owner only, the rest see all low
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            m_rsp_o[p] = (locked_q && grant_q == PORT_IDX_W'(p)) ? s_rsp_i : '0;
        end
    end

    assign fin = (s_req_o.r_ready && s_rsp_i.r_valid)
              || (s_req_o.b_ready && s_rsp_i.b_valid);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            grant_q  <= '0;
            locked_q <= 1'b0;
            rr_ptr_q <= '0;
        end else if (!locked_q) begin
            if (pick_valid) begin
                grant_q  <= pick_idx;
                locked_q <= 1'b1;
            end
        end else if (fin) begin
            locked_q <= 1'b0;
            // move past the winner, wrap at the last port
            rr_ptr_q <= (grant_q == PORT_IDX_W'(NUM_PORTS - 1)) ? '0 : grant_q + 1'b1;
        end
    end

endmodule

//--- design/axi_sram.sv
`timescale 1ns/1ps

module axi_sram (
    input  logic               clock,
    input  logic               reset,
    input  axi_pkg::axi_m2s_t  axi_i,
    output axi_pkg::axi_s2m_t  axi_o
);
    import axi_pkg::*;

    logic [DATA_W-1:0] mem [MEM_WORDS];

    logic              r_pend_q;    // read data waiting for r_ready
    logic [DATA_W-1:0] r_data_q;
    logic [1:0]        r_resp_q;
    logic              b_pend_q;    // write response waiting for b_ready
    logic [1:0]        b_resp_q;

    logic                 idle;
    logic                 rd_go, wr_go;
    logic                 ar_ok, aw_ok;   // address inside the array
    logic [MEM_IDX_W-1:0] ar_idx, aw_idx;

    assign idle  = !r_pend_q && !b_pend_q;
    assign rd_go = idle && axi_i.ar_valid;
    // write only when address and data both present, read has priority
    assign wr_go = idle && !axi_i.ar_valid && axi_i.aw_valid && axi_i.w_valid;

    // MEM_WORDS is a power of two, so high bits zero means in range
    assign ar_ok  = (axi_i.ar_addr[ADDR_W-1:ADDR_LSB+MEM_IDX_W] == '0);
    assign aw_ok  = (axi_i.aw_addr[ADDR_W-1:ADDR_LSB+MEM_IDX_W] == '0);
    assign ar_idx = axi_i.ar_addr[ADDR_LSB +: MEM_IDX_W];
    assign aw_idx = axi_i.aw_addr[ADDR_LSB +: MEM_IDX_W];

    always_comb begin
        axi_o          = '0;
        axi_o.ar_ready = idle;
        axi_o.aw_ready = wr_go;
        axi_o.w_ready  = wr_go;
        axi_o.r_valid  = r_pend_q;
        axi_o.r_data   = r_data_q;
        axi_o.r_resp   = r_resp_q;
        axi_o.b_valid  = b_pend_q;
        axi_o.b_resp   = b_resp_q;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            r_pend_q <= 1'b0;
            b_pend_q <= 1'b0;
        end else begin
            if (rd_go) r_pend_q <= 1'b1;
            else if (axi_i.r_ready) r_pend_q <= 1'b0;
            if (wr_go) b_pend_q <= 1'b1;
            else if (axi_i.b_ready) b_pend_q <= 1'b0;
        end
    end

    // array and response payload
    always_ff @(posedge clock) begin
        if (rd_go) begin
            r_data_q <= ar_ok ? mem[ar_idx] : '0;   // zero data on error
            r_resp_q <= ar_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (wr_go) begin
            b_resp_q <= aw_ok ? RESP_OKAY : RESP_SLVERR;
            for (int b = 0; b < STRB_W; b++) begin
                if (aw_ok && axi_i.w_strb[b]) mem[aw_idx][b*8 +: 8] <= axi_i.w_data[b*8 +: 8];
            end
        end
    end

endmodule

//--- design/axi_mem_top.sv
`timescale 1ns/1ps

module axi_mem_top (
    input  logic               clock,
    input  logic               reset,
    input  logic               rw_valid_i [axi_pkg::NUM_PORTS],
    input  axi_pkg::rw_req_t   rw_req_i   [axi_pkg::NUM_PORTS],
    output logic               rw_ready_o [axi_pkg::NUM_PORTS],
    output axi_pkg::rw_resp_t  rw_resp_o  [axi_pkg::NUM_PORTS]
);
    import axi_pkg::*;

    logic     start    [NUM_PORTS];   // latch to bridge kick
    rw_req_t  held_req [NUM_PORTS];
    axi_m2s_t m_req    [NUM_PORTS];   // bridge side of the arbiter
    axi_s2m_t m_rsp    [NUM_PORTS];
    axi_m2s_t s_req;                  // shared bus to the sram
    axi_s2m_t s_rsp;

    rw_req_latch rw_req_latch_i (
        .clock      (clock),
        .reset      (reset),
        .rw_valid_i (rw_valid_i),
        .rw_req_i   (rw_req_i),
        .done_i     (rw_ready_o),   // done pulse frees the port
        .start_o    (start),
        .req_o      (held_req)
    );

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        axi_ls axi_ls_i (
            .clock   (clock),
            .reset   (reset),
            .start_i (start[p]),
            .req_i   (held_req[p]),
            .done_o  (rw_ready_o[p]),
            .resp_o  (rw_resp_o[p]),
            .axi_o   (m_req[p]),
            .axi_i   (m_rsp[p])
        );
    end

    axi_arbiter axi_arbiter_i (
        .clock   (clock),
        .reset   (reset),
        .m_req_i (m_req),
        .m_rsp_o (m_rsp),
        .s_req_o (s_req),
        .s_rsp_i (s_rsp)
    );

    axi_sram axi_sram_i (
        .clock (clock),
        .reset (reset),
        .axi_i (s_req),
        .axi_o (s_rsp)
    );

endmodule

//--- tb/axi_mem_properties.sv
`timescale 1ns/1ps

module axi_mem_properties (
    input  logic               clock,
    input  logic               reset,
    input  logic               start_i,
    input  logic               done_i,
    input  axi_pkg::ls_state_e state_i,
    input  axi_pkg::axi_m2s_t  axi_m_i,
    input  axi_pkg::axi_s2m_t  axi_s_i
);
    import axi_pkg::*;

    int fails = 0;   // failed property count

    ar_hold: assert property (@(posedge clock) disable iff (!reset)
                              axi_m_i.ar_valid && !axi_s_i.ar_ready |=> axi_m_i.ar_valid)
        else begin
            $error("ar_valid dropped before ar_ready");
            fails++;
        end

    aw_hold: assert property (@(posedge clock) disable iff (!reset)
                              axi_m_i.aw_valid && !axi_s_i.aw_ready |=> axi_m_i.aw_valid)
        else begin
            $error("aw_valid dropped before aw_ready");
            fails++;
        end

    // address frozen while waiting
    ar_addr_stable: assert property (@(posedge clock) disable iff (!reset)
                                     axi_m_i.ar_valid && !axi_s_i.ar_ready
                                     |=> $stable(axi_m_i.ar_addr))
        else begin
            $error("ar_addr changed while ar_valid high");
            fails++;
        end

    done_single: assert property (@(posedge clock) disable iff (!reset)
                                  done_i |=> !done_i)
        else begin
            $error("done_o high two cycles in a row");
            fails++;
        end

    start_idle: assert property (@(posedge clock) disable iff (!reset)
                                 start_i |-> state_i == LS_IDLE)
        else begin
            $error("start_i while bridge busy");
            fails++;
        end

endmodule

bind axi_ls axi_mem_properties axi_mem_properties_i (
    .clock   (clock),
    .reset   (reset),
    .start_i (start_i),
    .done_i  (done_o),
    .state_i (state_q),
    .axi_m_i (axi_o),
    .axi_s_i (axi_i)
);

//--- tb/axi_mem_tb.sv
`timescale 1ns/1ps

module axi_mem_tb;
    import axi_pkg::*;

    localparam int CLK_HALF     = 4;     // 8 ns clock
    localparam int RESET_CYCLES = 16;
    localparam int TOTAL_REQS   = 52;    // every request issued by the tests below
    localparam logic [ADDR_W-1:0] OOR_BASE = ADDR_W'(MEM_WORDS * STRB_W); // first byte past sram

    logic     clock;
    logic     reset;
    logic     rw_valid [NUM_PORTS];
    rw_req_t  rw_req   [NUM_PORTS];
    logic     rw_ready [NUM_PORTS];
    rw_resp_t rw_resp  [NUM_PORTS];

    logic [DATA_W-1:0] shadow  [MEM_WORDS];   // expected sram contents
    logic              written [MEM_WORDS];   // word holds known data
    int                seed;
    int                assert_fails [NUM_PORTS];
    int                total_fails;

    axi_mem_top axi_mem_top_i (
        .clock      (clock),
        .reset      (reset),
        .rw_valid_i (rw_valid),
        .rw_req_i   (rw_req),
        .rw_ready_o (rw_ready),
        .rw_resp_o  (rw_resp)
    );

    // property failure counts from the bound checkers
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_fails
        assign assert_fails[p] = axi_mem_top_i.g_port[p].axi_ls_i.axi_mem_properties_i.fails;
    end

    always #CLK_HALF clock = ~clock;

    task automatic stop_with_failure();
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    // first property failure in a bridge ends the run
    always @(negedge clock) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (assert_fails[p] != 0) begin
                $display("property failure in bridge %0d", p);
                stop_with_failure();
            end
        end
    end

    task automatic check_ready(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] got, exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_resp(input string name, input rw_resp_t got, exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got rdata=%h err=%b expected rdata=%h err=%b",
                     $time, name, got.rdata, got.err, exp.rdata, exp.err);
            stop_with_failure();
        end
    endtask

    function automatic logic in_range(input logic [ADDR_W-1:0] addr);
        return addr < OOR_BASE;
    endfunction

    function automatic logic [MEM_IDX_W-1:0] word_idx(input logic [ADDR_W-1:0] addr);
        return MEM_IDX_W'(addr / STRB_W);   // 8 bytes per word
    endfunction

    // one cycle pulse, then wait for the ready pulse
    task automatic run_req(input int p, input rw_req_t req, output rw_resp_t resp);
        @(posedge clock);
        #1;
        rw_valid[p] = 1'b1;
        rw_req[p]   = req;
        @(posedge clock);
        #1;
        rw_valid[p] = 1'b0;
        rw_req[p]   = '0;
        do begin
            @(posedge clock);
            #1;
            // response bus must stay zero until the ready pulse
            if (!rw_ready[p]) check_resp($sformatf("rw_resp_o[%0d] idle", p), rw_resp[p], '0);
        end while (!rw_ready[p]);
        resp = rw_resp[p];
    endtask

    task automatic do_write(input int p, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
        rw_req_t  req;
        rw_resp_t resp;
        rw_resp_t exp;
        req = '{op: RW_WRITE, addr: addr, wdata: data, wstrb: strb};
        run_req(p, req, resp);
        exp = '{rdata: {DATA_W{1'b0}}, err: !in_range(addr)};   // writes return no data
        check_resp($sformatf("rw_resp_o[%0d] write", p), resp, exp);
        if (in_range(addr)) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (strb[b]) shadow[word_idx(addr)][b*8 +: 8] = data[b*8 +: 8];
            end
            written[word_idx(addr)] = 1'b1;
        end
    endtask

    task automatic do_read(input int p, input logic [ADDR_W-1:0] addr);
        rw_req_t  req;
        rw_resp_t resp;
        rw_resp_t exp;
        req = '{op: RW_READ, addr: addr, wdata: {DATA_W{1'b0}}, wstrb: {STRB_W{1'b0}}};
        run_req(p, req, resp);
        exp.err   = !in_range(addr);
        exp.rdata = exp.err ? {DATA_W{1'b0}} : shadow[word_idx(addr)];
        check_data($sformatf("rw_resp_o[%0d].rdata", p), resp.rdata, exp.rdata);
        check_resp($sformatf("rw_resp_o[%0d]", p), resp, exp);
    endtask

    task automatic test_idle();
        repeat (10) begin
            @(posedge clock);
            #1;
            for (int p = 0; p < NUM_PORTS; p++) begin
                check_ready("rw_ready_o", rw_ready[p], 1'b0);
                check_resp("rw_resp_o", rw_resp[p], '0);
            end
        end
    endtask

    task automatic test_write_read();
        do_write(0, 32'h0000_0040, 64'h0123_4567_89ab_cdef, '1);
        do_read(1, 32'h0000_0040);   // other port sees the same word
    endtask

    task automatic test_partial();
        do_write(0, 32'h0000_0080, 64'h1111_2222_3333_4444, '1);
        do_write(1, 32'h0000_0080, 64'haaaa_bbbb_cccc_dddd, 8'b0101_1010);
        do_read(0, 32'h0000_0080);
    endtask

    // both ports in the same cycle, finish order left to the arbiter
    task automatic test_both_ports();
        do_write(1, 32'h0000_00c0, 64'hfeed_face_dead_beef, '1);
        fork
            do_read(1, 32'h0000_00c0);
            do_write(0, 32'h0000_0100, 64'h0f0f_1e1e_2d2d_3c3c, '1);
        join
    endtask

    task automatic test_out_of_range();
        do_write(0, 32'h0000_0028, 64'h5555_6666_7777_8888, '1);
        do_read(1, OOR_BASE + 32'h28);
        do_write(0, OOR_BASE + 32'h28, 64'hbad0_bad0_bad0_bad0, '1);   // aliases word 5
        do_read(1, 32'h0000_0028);
    endtask

    task automatic test_random(input int count);
        int                p;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              wr;
        for (int n = 0; n < count; n++) begin
            p    = {$random(seed)} % NUM_PORTS;
            addr = ({$random(seed)} % 32) * STRB_W;   // small window so reads hit writes
            data = {$random(seed), $random(seed)};
            strb = STRB_W'($random(seed));
            wr   = ({$random(seed)} % 2) == 1;
            if (!written[word_idx(addr)]) begin
                wr   = 1'b1;   // unknown word gets a full write first
                strb = '1;
            end
            if (wr) do_write(p, addr, data, strb);
            else do_read(p, addr);
        end
    endtask

    initial begin
        repeat (TOTAL_REQS * 40 + RESET_CYCLES) @(posedge clock);
        $display("watchdog expired, a request never completed");
        stop_with_failure();
    end

    initial begin
        seed  = 32'hc05a_1f43;
        clock = 1'b0;
        reset = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            rw_valid[p] = 1'b0;
            rw_req[p]   = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i]  = '0;
            written[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        #1 reset = 1'b1;
        test_idle();
        test_write_read();
        test_partial();
        test_both_ports();
        test_out_of_range();
        test_random(40);
        total_fails = 0;
        for (int p = 0; p < NUM_PORTS; p++) total_fails += assert_fails[p];
        if (total_fails == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("%0d property failures in the bridges", total_fails);
            stop_with_failure();
        end
    end

endmodule

//--- filelist.f
design/axi_pkg.sv
design/rw_req_latch.sv
design/axi_ls.sv
design/axi_arbiter.sv
design/axi_sram.sv
design/axi_mem_top.sv
tb/axi_mem_properties.sv
tb/axi_mem_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = axi_mem_tb
FILELIST  = filelist.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
